// File: hazard_cfg_pkg.sv
/*
 * hazard unit configuration
 * default sizes for the pending-write table and the slot allocator
 */

`default_nettype none

package hazard_cfg_pkg;

    // slots in the pending-write table
    localparam int DEF_DEPTH = 8;

    // one free slot per instruction of the pair
    localparam int MIN_FREE = 2;

endpackage : hazard_cfg_pkg

`default_nettype wire

// File: hazard_inst_pkg.sv
/*
 * instruction field types for the hazard unit
 * register addresses and the issue code of an instruction pair
 */

`default_nettype none

package hazard_inst_pkg;

    localparam int REG_ADDR_W = 5;

    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t REG_X0 = '0; // hardwired zero, never tracked

    // one issue bit per instruction of the pair
    typedef logic [1:0] issue_t;

    localparam int ISS_INST1 = 0; // older instruction
    localparam int ISS_INST2 = 1; // younger instruction

    localparam issue_t ISSUE_NONE  = 2'b00;
    localparam issue_t ISSUE_FIRST = 2'b01;
    localparam issue_t ISSUE_BOTH  = 2'b11;

endpackage : hazard_inst_pkg

`default_nettype wire

// File: pending_table.sv
/*
 * pending-write table
 * one slot per issued writer that has not written back yet,
 * filled at issue and cleared by either commit port
 */

`default_nettype none

module pending_table #(
    parameter int DEPTH = hazard_cfg_pkg::DEF_DEPTH
) (
    input  wire                                          clk,
    input  wire                                          rst_n,

    input  wire hazard_inst_pkg::issue_t                 issue_i,

    input  wire                                          inst1_valid_i,
    input  wire                                          inst1_rd_we_i,
    input  wire hazard_inst_pkg::reg_addr_t              inst1_rd_i,
    input  wire [$clog2(DEPTH)-1:0]                      inst1_id_i,

    input  wire                                          inst2_valid_i,
    input  wire                                          inst2_rd_we_i,
    input  wire hazard_inst_pkg::reg_addr_t              inst2_rd_i,
    input  wire [$clog2(DEPTH)-1:0]                      inst2_id_i,

    input  wire                                          commit_valid_i,
    input  wire [$clog2(DEPTH)-1:0]                      commit_id_i,
    input  wire                                          commit2_valid_i,
    input  wire [$clog2(DEPTH)-1:0]                      commit2_id_i,

    output logic [DEPTH-1:0]                             slot_valid_o,
    output hazard_inst_pkg::reg_addr_t [DEPTH-1:0]       slot_rd_o
);

    import hazard_inst_pkg::*;

    logic [DEPTH-1:0]      slot_valid_q;
    reg_addr_t [DEPTH-1:0] slot_rd_q;
    logic                  wr1;
    logic                  wr2;
    logic                  cmt_on_id1;
    logic                  cmt_on_id2;

    // a slot is only taken by an issued instruction that really writes
    assign wr1 = issue_i[ISS_INST1] && inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != REG_X0);
    assign wr2 = issue_i[ISS_INST2] && inst2_valid_i && inst2_rd_we_i && (inst2_rd_i != REG_X0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot_valid_q <= '0;
        end else begin
            if (commit_valid_i) begin
                slot_valid_q[commit_id_i] <= 1'b0;
            end
            if (commit2_valid_i) begin
                slot_valid_q[commit2_id_i] <= 1'b0;
            end
            // issue writes last so they win over a commit
            if (wr1) begin
                slot_valid_q[inst1_id_i] <= 1'b1;
            end
            if (wr2) begin
                slot_valid_q[inst2_id_i] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr1) begin
            slot_rd_q[inst1_id_i] <= inst1_rd_i;
        end
        if (wr2) begin
            slot_rd_q[inst2_id_i] <= inst2_rd_i;
        end
    end

    assign slot_valid_o = slot_valid_q;
    assign slot_rd_o    = slot_rd_q;

    // commit retiring the slot an instruction is about to take
    assign cmt_on_id1 = (commit_valid_i && (commit_id_i == inst1_id_i)) ||
                        (commit2_valid_i && (commit2_id_i == inst1_id_i));
    assign cmt_on_id2 = (commit_valid_i && (commit_id_i == inst2_id_i)) ||
                        (commit2_valid_i && (commit2_id_i == inst2_id_i));

    // allocator IDs must point at a slot that is free or retiring
    a_wr1_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        wr1 |-> (!slot_valid_q[inst1_id_i] || cmt_on_id1));
    a_wr2_free_slot: assert property (@(posedge clk) disable iff (!rst_n)
        wr2 |-> (!slot_valid_q[inst2_id_i] || cmt_on_id2));

    // write-back only for an instruction still tracked
    a_commit_pending: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid_i |-> slot_valid_q[commit_id_i]);
    a_commit2_pending: assert property (@(posedge clk) disable iff (!rst_n)
        commit2_valid_i |-> slot_valid_q[commit2_id_i]);

endmodule : pending_table

`default_nettype wire

// File: slot_alloc.sv
/*
 * slot allocator
 * picks the lowest free slot for inst1, the next free one after it for
 * inst2, and flags whether the table has room for a pair
 */

`default_nettype none

module slot_alloc #(
    parameter int DEPTH = hazard_cfg_pkg::DEF_DEPTH
) (
    input  wire  [DEPTH-1:0]         slot_valid_i,
    input  wire                      inst1_valid_i,
    input  wire                      inst2_valid_i,
    output logic [$clog2(DEPTH)-1:0] free_id1_o,
    output logic [$clog2(DEPTH)-1:0] free_id2_o,
    output logic                     room_ok_o
);

    import hazard_cfg_pkg::*;

    localparam int ID_W  = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [ID_W-1:0]  lowest_free;
    logic [ID_W-1:0]  next_free;
    logic [CNT_W-1:0] used_cnt;

    // downward scan, last hit is the lowest free slot
    always_comb begin
        lowest_free = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (!slot_valid_i[i]) begin
                lowest_free = ID_W'(i);
            end
        end
    end

    // closest free slot above inst1's, wrapping
    always_comb begin
        int idx;
        next_free = '0;
        for (int k = DEPTH - 1; k >= 1; k--) begin
            idx = (int'(free_id1_o) + k) % DEPTH;
            if (!slot_valid_i[idx]) begin
                next_free = ID_W'(idx);
            end
        end
    end

    always_comb begin
        used_cnt = '0;
        for (int i = 0; i < DEPTH; i++) begin
            used_cnt = used_cnt + CNT_W'(slot_valid_i[i]);
        end
    end

    assign room_ok_o  = (int'(used_cnt) <= DEPTH - MIN_FREE);
    assign free_id1_o = inst1_valid_i ? lowest_free : '0;
    assign free_id2_o = (inst2_valid_i && room_ok_o) ? next_free : '0;

    // a pair sharing one slot would corrupt the table on issue
    always_comb begin
        if (inst1_valid_i && inst2_valid_i && room_ok_o) begin
            a_ids_differ: assert final (free_id1_o != free_id2_o)
                else $error("slot_alloc: both instructions got slot %0d", free_id1_o);
        end
    end

endmodule : slot_alloc

`default_nettype wire

// File: hazard_check.sv
/*
 * table hazard check for one instruction
 * RAW on rs1/rs2 and WAW on rd against every live pending slot
 */

`default_nettype none

module hazard_check #(
    parameter int DEPTH = hazard_cfg_pkg::DEF_DEPTH
) (
    input  wire                                          valid_i,
    input  wire                                          rd_we_i,
    input  wire hazard_inst_pkg::reg_addr_t              rd_i,
    input  wire hazard_inst_pkg::reg_addr_t              rs1_i,
    input  wire hazard_inst_pkg::reg_addr_t              rs2_i,

    input  wire [DEPTH-1:0]                              slot_valid_i,
    input  wire hazard_inst_pkg::reg_addr_t [DEPTH-1:0]  slot_rd_i,

    input  wire                                          commit_valid_i,
    input  wire [$clog2(DEPTH)-1:0]                      commit_id_i,
    input  wire                                          commit2_valid_i,
    input  wire [$clog2(DEPTH)-1:0]                      commit2_id_i,

    output logic                                         table_hazard_o
);

    import hazard_inst_pkg::*;

    localparam int ID_W = $clog2(DEPTH);

    logic             rs1_chk;
    logic             rs2_chk;
    logic             rd_chk;
    logic [DEPTH-1:0] live;
    logic [DEPTH-1:0] raw_hit;
    logic [DEPTH-1:0] waw_hit;

    // x0 never depends on anything
    assign rs1_chk = valid_i && (rs1_i != REG_X0);
    assign rs2_chk = valid_i && (rs2_i != REG_X0);
    assign rd_chk  = valid_i && rd_we_i && (rd_i != REG_X0);

    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        // result is written back this cycle, so no longer a hazard
        assign live[i] = slot_valid_i[i] &&
                         !(commit_valid_i && (commit_id_i == ID_W'(i))) &&
                         !(commit2_valid_i && (commit2_id_i == ID_W'(i)));

        assign raw_hit[i] = live[i] && ((rs1_chk && (rs1_i == slot_rd_i[i])) ||
                                        (rs2_chk && (rs2_i == slot_rd_i[i])));
        assign waw_hit[i] = live[i] && rd_chk && (rd_i == slot_rd_i[i]);
    end

    assign table_hazard_o = |(raw_hit | waw_hit);

endmodule : hazard_check

`default_nettype wire

// File: issue_ctrl.sv
/*
 * issue control
 * checks inst2 against inst1's write and picks the issue code
 * from room, interrupt, serialization and hazard levels
 */

`default_nettype none

module issue_ctrl #(
    parameter int DEPTH = hazard_cfg_pkg::DEF_DEPTH
) (
    input  wire                              inst1_valid_i,
    input  wire                              inst1_rd_we_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst1_rd_i,

    input  wire                              inst2_valid_i,
    input  wire                              inst2_rd_we_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst2_rd_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst2_rs1_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst2_rs2_i,

    input  wire                              inst1_table_hazard_i,
    input  wire                              inst2_table_hazard_i,
    input  wire                              room_ok_i,

    input  wire                              irq_req_i,
    input  wire                              inst1_jump_i,
    input  wire                              inst1_branch_i,

    input  wire [$clog2(DEPTH)-1:0]          free_id1_i,
    input  wire [$clog2(DEPTH)-1:0]          free_id2_i,

    output hazard_inst_pkg::issue_t          issue_o,
    output logic [$clog2(DEPTH)-1:0]         inst1_id_o,
    output logic [$clog2(DEPTH)-1:0]         inst2_id_o
);

    import hazard_inst_pkg::*;

    logic inst1_writes;
    logic pair_raw;
    logic pair_waw;
    logic pair_hazard;

    assign inst1_writes = inst1_valid_i && inst1_rd_we_i && (inst1_rd_i != REG_X0);

    // rd is nonzero here, so a match also means a nonzero source
    assign pair_raw = inst2_valid_i && ((inst2_rs1_i == inst1_rd_i) ||
                                        (inst2_rs2_i == inst1_rd_i));
    assign pair_waw = inst2_valid_i && inst2_rd_we_i && (inst2_rd_i == inst1_rd_i);

    assign pair_hazard = inst1_writes && (pair_raw || pair_waw);

    always_comb begin
        if (!room_ok_i || irq_req_i || inst1_table_hazard_i) begin
            issue_o = ISSUE_NONE;       // nothing may go
        end else if (inst1_jump_i || inst1_branch_i) begin
            issue_o = ISSUE_FIRST;      // serialize behind control flow
        end else if (inst2_table_hazard_i || pair_hazard) begin
            issue_o = ISSUE_FIRST;      // younger one waits
        end else begin
            issue_o = ISSUE_BOTH;
        end
    end

    // IDs only mean something for issued instructions
    assign inst1_id_o = issue_o[ISS_INST1] ? free_id1_i : '0;
    assign inst2_id_o = issue_o[ISS_INST2] ? free_id2_i : '0;

endmodule : issue_ctrl

`default_nettype wire

// File: hazard_unit.sv
/*
 * dual-issue hazard unit
 * tracks pending writes and decides how much of the instruction pair
 * may issue each cycle
 */

`default_nettype none

module hazard_unit #(
    parameter int DEPTH = hazard_cfg_pkg::DEF_DEPTH
) (
    input  wire                              clk,
    input  wire                              rst_n,

    input  wire                              inst1_valid_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst1_rd_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst1_rs1_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst1_rs2_i,
    input  wire                              inst1_rd_we_i,

    input  wire                              inst2_valid_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst2_rd_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst2_rs1_i,
    input  wire hazard_inst_pkg::reg_addr_t  inst2_rs2_i,
    input  wire                              inst2_rd_we_i,

    input  wire                              commit_valid_i,   // write-back port 1
    input  wire [$clog2(DEPTH)-1:0]          commit_id_i,
    input  wire                              commit2_valid_i,  // write-back port 2
    input  wire [$clog2(DEPTH)-1:0]          commit2_id_i,

    input  wire                              inst1_jump_i,
    input  wire                              inst1_branch_i,
    input  wire                              irq_req_i,

    output hazard_inst_pkg::issue_t          issue_o,
    output logic [$clog2(DEPTH)-1:0]         inst1_id_o,
    output logic [$clog2(DEPTH)-1:0]         inst2_id_o,
    output logic                             lock_o            // some write still pending
);

    import hazard_inst_pkg::*;

    localparam int ID_W = $clog2(DEPTH);

    logic [DEPTH-1:0]      slot_valid;
    reg_addr_t [DEPTH-1:0] slot_rd;
    logic [ID_W-1:0]       free_id1;
    logic [ID_W-1:0]       free_id2;
    logic                  room_ok;
    logic                  inst1_table_hazard;
    logic                  inst2_table_hazard;

    pending_table #(.DEPTH(DEPTH)) u_table (
        .clk, .rst_n,
        .issue_i(issue_o),
        .inst1_valid_i, .inst1_rd_we_i, .inst1_rd_i, .inst1_id_i(free_id1),
        .inst2_valid_i, .inst2_rd_we_i, .inst2_rd_i, .inst2_id_i(free_id2),
        .commit_valid_i, .commit_id_i, .commit2_valid_i, .commit2_id_i,
        .slot_valid_o(slot_valid), .slot_rd_o(slot_rd)
    );

    slot_alloc #(.DEPTH(DEPTH)) u_alloc (
        .slot_valid_i(slot_valid), .inst1_valid_i, .inst2_valid_i,
        .free_id1_o(free_id1), .free_id2_o(free_id2), .room_ok_o(room_ok)
    );

    hazard_check #(.DEPTH(DEPTH)) u_check1 (
        .valid_i(inst1_valid_i), .rd_we_i(inst1_rd_we_i), .rd_i(inst1_rd_i),
        .rs1_i(inst1_rs1_i), .rs2_i(inst1_rs2_i),
        .slot_valid_i(slot_valid), .slot_rd_i(slot_rd),
        .commit_valid_i, .commit_id_i, .commit2_valid_i, .commit2_id_i,
        .table_hazard_o(inst1_table_hazard)
    );

    hazard_check #(.DEPTH(DEPTH)) u_check2 (
        .valid_i(inst2_valid_i), .rd_we_i(inst2_rd_we_i), .rd_i(inst2_rd_i),
        .rs1_i(inst2_rs1_i), .rs2_i(inst2_rs2_i),
        .slot_valid_i(slot_valid), .slot_rd_i(slot_rd),
        .commit_valid_i, .commit_id_i, .commit2_valid_i, .commit2_id_i,
        .table_hazard_o(inst2_table_hazard)
    );

    issue_ctrl #(.DEPTH(DEPTH)) u_ctrl (
        .inst1_valid_i, .inst1_rd_we_i, .inst1_rd_i,
        .inst2_valid_i, .inst2_rd_we_i, .inst2_rd_i, .inst2_rs1_i, .inst2_rs2_i,
        .inst1_table_hazard_i(inst1_table_hazard),
        .inst2_table_hazard_i(inst2_table_hazard),
        .room_ok_i(room_ok),
        .irq_req_i, .inst1_jump_i, .inst1_branch_i,
        .free_id1_i(free_id1), .free_id2_i(free_id2),
        .issue_o, .inst1_id_o, .inst2_id_o
    );

    assign lock_o = |slot_valid;

endmodule : hazard_unit

`default_nettype wire

// File: tb_hazard_unit.sv
/*
 * testbench for the dual-issue hazard unit
 * random instruction pairs and commits checked against a slot model
 */

`default_nettype none

module tb_hazard_unit;

    import hazard_inst_pkg::*;

    localparam int DEPTH        = 8;
    localparam int ID_W         = $clog2(DEPTH);
    localparam int RESET_CYCLES = 10;
    localparam int RUN_CYCLES   = 2000;
    localparam int MAX_CYCLES   = RUN_CYCLES + 100; // reset, fill, drains and margin

    logic            clk;
    logic            rst_n;
    logic            inst1_valid, inst1_rd_we;
    reg_addr_t       inst1_rd, inst1_rs1, inst1_rs2;
    logic            inst2_valid, inst2_rd_we;
    reg_addr_t       inst2_rd, inst2_rs1, inst2_rs2;
    logic            commit_valid, commit2_valid;
    logic [ID_W-1:0] commit_id, commit2_id;
    logic            inst1_jump, inst1_branch, irq_req;
    issue_t          issue;
    logic [ID_W-1:0] inst1_id, inst2_id;
    logic            lock;

    // reference state
    logic [DEPTH-1:0] m_valid;
    reg_addr_t        m_rd [DEPTH];
    issue_t           exp_issue;
    int               exp_id1, exp_id2;
    logic             exp_lock;

    integer seed      = 32'h134a;
    int     cycle_cnt = 0;

    hazard_unit #(.DEPTH(DEPTH)) uut (
        .clk(clk), .rst_n(rst_n),
        .inst1_valid_i(inst1_valid), .inst1_rd_i(inst1_rd), .inst1_rs1_i(inst1_rs1),
        .inst1_rs2_i(inst1_rs2), .inst1_rd_we_i(inst1_rd_we),
        .inst2_valid_i(inst2_valid), .inst2_rd_i(inst2_rd), .inst2_rs1_i(inst2_rs1),
        .inst2_rs2_i(inst2_rs2), .inst2_rd_we_i(inst2_rd_we),
        .commit_valid_i(commit_valid), .commit_id_i(commit_id),
        .commit2_valid_i(commit2_valid), .commit2_id_i(commit2_id),
        .inst1_jump_i(inst1_jump), .inst1_branch_i(inst1_branch), .irq_req_i(irq_req),
        .issue_o(issue), .inst1_id_o(inst1_id), .inst2_id_o(inst2_id), .lock_o(lock)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERR %s expected %0d actual %0d", name, expected, actual);
            $display("Something failed");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    function automatic int rand_below(input int n);
        rand_below = ($random(seed) & 32'h7fff_ffff) % n;
    endfunction

    // true when a slot still holds a result nobody has written back
    function automatic bit slot_live(input int i);
        slot_live = m_valid[i] && !(commit_valid && commit_id == i) &&
                    !(commit2_valid && commit2_id == i);
    endfunction

    function automatic bit table_hit(input logic vld, input logic we, input reg_addr_t rd,
                                     input reg_addr_t rs1, input reg_addr_t rs2);
        table_hit = 1'b0;
        for (int i = 0; i < DEPTH; i++) begin
            if (vld && slot_live(i)) begin
                if ((rs1 != 0 && rs1 == m_rd[i]) || (rs2 != 0 && rs2 == m_rd[i]) ||
                    (we && rd != 0 && rd == m_rd[i])) begin
                    table_hit = 1'b1;
                end
            end
        end
    endfunction

    task automatic compute_expected();
        int  used;
        int  lowest;
        int  base;
        int  nxt;
        bit  found;
        bit  room;
        bit  pair;
        used  = 0;
        found = 0;
        lowest = 0;
        for (int i = 0; i < DEPTH; i++) begin
            used += m_valid[i];
            if (!found && !m_valid[i]) begin
                lowest = i;
                found  = 1;
            end
        end
        room = (used <= DEPTH - 2);
        base = inst1_valid ? lowest : 0;
        found = 0;
        nxt   = 0;
        for (int k = 1; k < DEPTH; k++) begin   // walk upward from base, wrapping
            if (!found && !m_valid[(base + k) % DEPTH]) begin
                nxt   = (base + k) % DEPTH;
                found = 1;
            end
        end
        pair = inst1_valid && inst1_rd_we && inst1_rd != 0 && inst2_valid &&
               (inst2_rs1 == inst1_rd || inst2_rs2 == inst1_rd ||
                (inst2_rd_we && inst2_rd == inst1_rd));
        if (!room || irq_req ||
            table_hit(inst1_valid, inst1_rd_we, inst1_rd, inst1_rs1, inst1_rs2))
            exp_issue = 2'b00;
        else if (inst1_jump || inst1_branch)
            exp_issue = 2'b01;
        else if (pair || table_hit(inst2_valid, inst2_rd_we, inst2_rd, inst2_rs1, inst2_rs2))
            exp_issue = 2'b01;
        else
            exp_issue = 2'b11;
        exp_id1  = exp_issue[0] ? base : 0;
        exp_id2  = (exp_issue[1] && inst2_valid && room) ? nxt : 0;
        exp_lock = |m_valid;
    endtask

    task automatic update_model();
        if (commit_valid) m_valid[commit_id] = 1'b0;
        if (commit2_valid) m_valid[commit2_id] = 1'b0;
        if (exp_issue[0] && inst1_valid && inst1_rd_we && inst1_rd != 0) begin
            m_valid[exp_id1] = 1'b1;
            m_rd[exp_id1]    = inst1_rd;
        end
        if (exp_issue[1] && inst2_valid && inst2_rd_we && inst2_rd != 0) begin
            m_valid[exp_id2] = 1'b1;
            m_rd[exp_id2]    = inst2_rd;
        end
    endtask

    task automatic drive_idle();
        {inst1_valid, inst1_rd_we, inst2_valid, inst2_rd_we} = '0;
        {inst1_rd, inst1_rs1, inst1_rs2, inst2_rd, inst2_rs1, inst2_rs2} = '0;
        {commit_valid, commit_id, commit2_valid, commit2_id} = '0;
        {inst1_jump, inst1_branch, irq_req} = '0;
    endtask

    // each port retires a distinct pending slot with chance 1/n
    task automatic pick_commits(input int n);
        int pend[$];
        int pick;
        for (int i = 0; i < DEPTH; i++) if (m_valid[i]) pend.push_back(i);
        {commit_valid, commit_id, commit2_valid, commit2_id} = '0;
        if (pend.size() > 0 && rand_below(n) == 0) begin
            pick = rand_below(pend.size());
            commit_valid = 1'b1;
            commit_id    = ID_W'(pend[pick]);
            pend.delete(pick);
        end
        if (pend.size() > 0 && rand_below(n) == 0) begin
            pick = rand_below(pend.size());
            commit2_valid = 1'b1;
            commit2_id    = ID_W'(pend[pick]);
        end
    endtask

    task automatic drive_random();
        inst1_valid  = rand_below(8) != 0;
        inst1_rd_we  = rand_below(4) != 0;
        inst1_rd     = reg_addr_t'(rand_below(8)); // small range, frequent hits
        inst1_rs1    = reg_addr_t'(rand_below(8));
        inst1_rs2    = reg_addr_t'(rand_below(8));
        inst2_valid  = rand_below(8) != 0;
        inst2_rd_we  = rand_below(4) != 0;
        inst2_rd     = reg_addr_t'(rand_below(8));
        inst2_rs1    = reg_addr_t'(rand_below(8));
        inst2_rs2    = reg_addr_t'(rand_below(8));
        inst1_jump   = rand_below(8) == 0;
        inst1_branch = rand_below(8) == 0;
        irq_req      = rand_below(16) == 0;
        pick_commits(2);
    endtask

    // called right after driving on the falling edge
    task automatic step(input string name);
        compute_expected();
        #4;
        check({name, " issue"}, exp_issue, issue);
        check({name, " inst1_id"}, exp_id1, inst1_id);
        check({name, " inst2_id"}, exp_id2, inst2_id);
        check({name, " lock"}, exp_lock, lock);
        @(posedge clk);
        update_model();
    endtask

    // retire everything, two per cycle
    task automatic drain_table();
        while (m_valid != '0) begin
            @(negedge clk);
            drive_idle();
            pick_commits(1);
            step("drain");
        end
    endtask

    initial begin
        drive_idle();
        rst_n   = 1'b0;
        m_valid = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        #4;
        check("reset lock", 0, lock);
        check("reset issue", ISSUE_BOTH, issue);

        repeat (RUN_CYCLES) begin
            @(negedge clk);
            drive_random();
            step("random");
        end
        drain_table();

        // distinct writers and no commits until only one slot is free
        for (int r = 1; r < DEPTH; r++) begin
            @(negedge clk);
            drive_idle();
            inst1_valid = 1'b1;
            inst1_rd_we = 1'b1;
            inst1_rd    = reg_addr_t'(r);
            step("fill");
        end
        @(negedge clk);
        drive_idle();
        inst1_valid = 1'b1;
        inst2_valid = 1'b1;
        #4;
        check("full issue", ISSUE_NONE, issue);
        check("full lock", 1, lock);
        drain_table();

        @(negedge clk);
        drive_idle();
        #4;
        check("drain lock", 0, lock);
        check("drain issue", ISSUE_BOTH, issue);

        $display("Everything OK");
        $finish;
    end

endmodule : tb_hazard_unit

`default_nettype wire

// File: build.f
hazard_cfg_pkg.sv
hazard_inst_pkg.sv
pending_table.sv
slot_alloc.sv
hazard_check.sv
issue_ctrl.sv
hazard_unit.sv
tb_hazard_unit.sv

// File: Bender.yml
package:
  name: hazard_unit

sources:
  - hazard_cfg_pkg.sv
  - hazard_inst_pkg.sv
  - pending_table.sv
  - slot_alloc.sv
  - hazard_check.sv
  - issue_ctrl.sv
  - hazard_unit.sv
  - target: test
    files:
      - tb_hazard_unit.sv
